// ==== hdl/rx_pcs_pkg.sv ====
// blocks are assumed 66-bit aligned per lane and every limit in sync_cfg_t must be nonzero
package rx_pcs_pkg;

    // lane and block geometry
    localparam int N_LANES    = 4;
    localparam int NB_SH      = 2;
    localparam int NB_PAYLOAD = 64;

    // block sync counters
    localparam int NB_WINDOW  = 12;
    localparam int NB_INV_SH  = 11;
    localparam int NB_ERR_CNT = 16;

    // legal sync headers
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    // one 66-bit block, header in the msbs
    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } block_t;

    typedef block_t [N_LANES-1:0] lane_bus_t;

    typedef logic [NB_ERR_CNT-1:0] err_cnt_t;

    typedef err_cnt_t [N_LANES-1:0] err_bus_t;

    typedef logic [N_LANES-1:0] lock_vec_t;

    // static while running
    typedef struct packed {
        logic [NB_WINDOW-1:0] unlocked_limit;
        logic [NB_WINDOW-1:0] locked_limit;
        logic [NB_INV_SH-1:0] sh_invalid_limit;
    } sync_cfg_t;

    typedef enum logic {
        ST_UNLOCKED = 1'b0,
        ST_LOCKED   = 1'b1
    } lock_state_t;

endpackage

// ==== hdl/sh_window_counter.sv ====
// pulses are combinational from the registered counts and valid only with a nonzero i_cfg
`timescale 1ns/1ps

module sh_window_counter
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_accept,
    input  logic                  i_sh_ok,
    input  logic                  i_locked,
    input  logic                  i_clear,
    input  rx_pcs_pkg::sync_cfg_t i_cfg,
    output logic                  o_window_done,
    output logic                  o_limit_hit
);

    // run count when unlocked, block count when locked
    logic [rx_pcs_pkg::NB_WINDOW-1:0] win_cnt;
    logic [rx_pcs_pkg::NB_INV_SH-1:0] inv_cnt;

    logic [rx_pcs_pkg::NB_WINDOW:0]   win_next;
    logic [rx_pcs_pkg::NB_INV_SH:0]   inv_next;
    logic                             run_full;
    logic                             blk_full;
    logic                             inv_full;

    // one extra bit so the compare never wraps
    assign win_next = {1'b0, win_cnt} + 1'b1;
    assign inv_next = {1'b0, inv_cnt} + 1'b1;

    assign run_full = (win_next == {1'b0, i_cfg.unlocked_limit});
    assign blk_full = (win_next == {1'b0, i_cfg.locked_limit});
    assign inv_full = (inv_next == {1'b0, i_cfg.sh_invalid_limit});

    // the current block is the one that reaches the limit
    assign o_limit_hit   = i_accept && (i_locked ? (!i_sh_ok && inv_full) : (i_sh_ok && run_full));
    assign o_window_done = i_accept && i_locked && blk_full;

    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_clear)
        begin
            win_cnt <= '0;
            inv_cnt <= '0;
        end
        else if (i_accept)
        begin
            if (i_locked)
            begin
                win_cnt <= win_next[rx_pcs_pkg::NB_WINDOW-1:0];
                if (!i_sh_ok)
                begin
                    inv_cnt <= inv_next[rx_pcs_pkg::NB_INV_SH-1:0];
                end
            end
            else if (i_sh_ok)
            begin
                win_cnt <= win_next[rx_pcs_pkg::NB_WINDOW-1:0];
            end
            else
            begin
                // bad header breaks the run
                win_cnt <= '0;
            end
        end
    end

    // the fsm clear must keep every count inside its window
    a_count_in_limit : assert property (@(posedge i_clock) disable iff (i_reset)
        (win_cnt <= (i_locked ? i_cfg.locked_limit : i_cfg.unlocked_limit)) &&
        (inv_cnt <= i_cfg.sh_invalid_limit));

endmodule

// ==== hdl/block_lock_fsm.sv ====
// signal loss unlocks the lane even while blocks are not being accepted
`timescale 1ns/1ps

module block_lock_fsm
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_accept,
    input  logic i_sh_ok,
    input  logic i_signal_ok,
    input  logic i_window_done,
    input  logic i_limit_hit,
    output logic o_locked,
    output logic o_clear
);

    rx_pcs_pkg::lock_state_t state;
    rx_pcs_pkg::lock_state_t state_next;

    logic lock_event;
    logic unlock_event;
    logic window_event;

    // counter pulses qualified by the header direction
    assign lock_event   = i_accept && i_sh_ok && i_limit_hit;
    assign unlock_event = i_accept && !i_sh_ok && i_limit_hit;
    assign window_event = i_accept && i_window_done;

    always_comb
    begin
        state_next = state;
        o_clear    = 1'b0;
        if (!i_signal_ok)
        begin
            state_next = rx_pcs_pkg::ST_UNLOCKED;
            o_clear    = 1'b1;
        end
        else
        begin
            case (state)
                rx_pcs_pkg::ST_UNLOCKED:
                begin
                    if (lock_event)
                    begin
                        state_next = rx_pcs_pkg::ST_LOCKED;
                        o_clear    = 1'b1;
                    end
                end
                rx_pcs_pkg::ST_LOCKED:
                begin
                    // too many bad headers wins over window restart
                    if (unlock_event)
                    begin
                        state_next = rx_pcs_pkg::ST_UNLOCKED;
                        o_clear    = 1'b1;
                    end
                    else if (window_event)
                    begin
                        o_clear = 1'b1;
                    end
                end
                default:
                begin
                    state_next = rx_pcs_pkg::ST_UNLOCKED;
                    o_clear    = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            state <= rx_pcs_pkg::ST_UNLOCKED;
        else
            state <= state_next;
    end

    assign o_locked = (state == rx_pcs_pkg::ST_LOCKED);

    a_no_lock_after_loss : assert property (@(posedge i_clock) disable iff (i_reset)
        !i_signal_ok |=> !o_locked);

endmodule

// ==== hdl/lane_block_sync.sv ====
// one lane of block sync, i_accept is the shared valid and enable strobe
`timescale 1ns/1ps

module lane_block_sync
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_accept,
    input  logic                  i_signal_ok,
    input  rx_pcs_pkg::block_t    i_block,
    input  rx_pcs_pkg::sync_cfg_t i_cfg,
    output rx_pcs_pkg::block_t    o_block,
    output logic                  o_lock,
    output rx_pcs_pkg::err_cnt_t  o_err_count
);

    logic sh_ok;
    logic clear;
    logic locked;
    logic window_done;
    logic limit_hit;

    // only 01 and 10 are legal headers
    assign sh_ok = (i_block.sh == rx_pcs_pkg::SH_DATA) || (i_block.sh == rx_pcs_pkg::SH_CTRL);

    // data path, no reset on payload
    always_ff @(posedge i_clock)
    begin
        if (i_accept)
            o_block <= i_block;
    end

    // saturating bad header count, independent of lock
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_err_count <= '0;
        else if (i_accept && !sh_ok && (o_err_count != '1))
            o_err_count <= o_err_count + 1'b1;
    end

    block_lock_fsm block_lock_fsm_i
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_accept      (i_accept),
        .i_sh_ok       (sh_ok),
        .i_signal_ok   (i_signal_ok),
        .i_window_done (window_done),
        .i_limit_hit   (limit_hit),
        .o_locked      (locked),
        .o_clear       (clear)
    );

    sh_window_counter sh_window_counter_i
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_accept      (i_accept),
        .i_sh_ok       (sh_ok),
        .i_locked      (locked),
        .i_clear       (clear),
        .i_cfg         (i_cfg),
        .o_window_done (window_done),
        .o_limit_hit   (limit_hit)
    );

    assign o_lock = locked;

    a_err_monotonic : assert property (@(posedge i_clock) disable iff (i_reset)
        o_err_count >= $past(o_err_count));

endmodule

// ==== hdl/cor_status_reg.sv ====
// clear on read snapshot, only the rising edge of i_read clears and only for one cycle
`timescale 1ns/1ps

module cor_status_reg
#(
    parameter type T = logic
)
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_read,
    input  T     i_value,
    output T     o_value
);

    logic read_d;
    logic read_edge;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            read_d <= 1'b0;
        else
            read_d <= i_read;
    end

    assign read_edge = i_read && !read_d;

    // snapshot follows the source every cycle
    always_ff @(posedge i_clock)
    begin
        if (i_reset || read_edge)
            o_value <= T'('0);
        else
            o_value <= i_value;
    end

    a_clear_on_read : assert property (@(posedge i_clock) disable iff (i_reset)
        read_edge |=> (o_value == T'('0)));

endmodule

// ==== hdl/rx_block_sync_top.sv ====
// blocks enter pre-aligned on all lanes with one shared valid, no back-pressure
`timescale 1ns/1ps

module rx_block_sync_top
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_enable,
    input  logic                  i_valid,
    input  logic                  i_signal_ok,
    input  rx_pcs_pkg::lane_bus_t i_data,
    input  rx_pcs_pkg::sync_cfg_t i_cfg,
    input  logic                  i_read_lock,
    input  logic                  i_read_err,
    output rx_pcs_pkg::lane_bus_t o_data,
    output logic                  o_valid,
    output rx_pcs_pkg::lock_vec_t o_rf_block_lock,
    output rx_pcs_pkg::err_bus_t  o_rf_err_count
);

    logic                  accept;
    rx_pcs_pkg::lock_vec_t lane_lock;
    rx_pcs_pkg::err_bus_t  lane_err;

    // one accept strobe shared by every lane
    assign accept = i_valid && i_enable;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= accept;
    end

    for (genvar g = 0; g < rx_pcs_pkg::N_LANES; g++)
    begin : g_lane
        lane_block_sync lane_block_sync_i
        (
            .i_clock     (i_clock),
            .i_reset     (i_reset),
            .i_accept    (accept),
            .i_signal_ok (i_signal_ok),
            .i_block     (i_data[g]),
            .i_cfg       (i_cfg),
            .o_block     (o_data[g]),
            .o_lock      (lane_lock[g]),
            .o_err_count (lane_err[g])
        );
    end

    // register file side snapshots
    cor_status_reg #(.T(rx_pcs_pkg::lock_vec_t)) cor_lock_i
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_read  (i_read_lock),
        .i_value (lane_lock),
        .o_value (o_rf_block_lock)
    );

    cor_status_reg #(.T(rx_pcs_pkg::err_bus_t)) cor_err_i
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_read  (i_read_err),
        .i_value (lane_err),
        .o_value (o_rf_err_count)
    );

endmodule

// ==== sim/rx_block_sync_tb.sv ====
// fixed config 8/16/4 and i_signal_ok only dropped while i_enable is high
`timescale 1ns/1ps

module rx_block_sync_tb;

    localparam int LN = rx_pcs_pkg::N_LANES;

    logic                             i_clock;
    logic                             i_reset;
    logic                             i_enable;
    logic                             i_valid;
    logic                             i_signal_ok;
    rx_pcs_pkg::lane_bus_t            i_data;
    rx_pcs_pkg::sync_cfg_t            i_cfg;
    logic                             i_read_lock;
    logic                             i_read_err;
    rx_pcs_pkg::lane_bus_t            o_data;
    logic                             o_valid;
    rx_pcs_pkg::lock_vec_t            o_rf_block_lock;
    rx_pcs_pkg::err_bus_t             o_rf_err_count;

    // reference model state
    logic                             m_valid;
    rx_pcs_pkg::lane_bus_t            m_data;
    rx_pcs_pkg::lock_vec_t            m_lock;
    rx_pcs_pkg::err_bus_t             m_err;
    rx_pcs_pkg::lock_vec_t            m_rf_lock;
    rx_pcs_pkg::err_bus_t             m_rf_err;
    logic                             m_rd_lock_q;
    logic                             m_rd_err_q;
    logic [rx_pcs_pkg::NB_WINDOW-1:0] m_run [LN];
    logic [rx_pcs_pkg::NB_INV_SH-1:0] m_inv [LN];
    logic                             t_good;
    logic                             t_lock;
    logic [rx_pcs_pkg::NB_WINDOW-1:0] t_run;
    logic [rx_pcs_pkg::NB_INV_SH-1:0] t_inv;
    int                               seed;

    rx_block_sync_top rx_block_sync_top_i (.*);

    initial
    begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    always @(posedge i_clock)
    begin
        if (i_reset)
        begin
            m_valid     <= 1'b0;
            m_lock      <= '0;
            m_err       <= '0;
            m_rf_lock   <= '0;
            m_rf_err    <= '0;
            m_rd_lock_q <= 1'b0;
            m_rd_err_q  <= 1'b0;
            for (int l = 0; l < LN; l++)
            begin
                m_run[l] <= '0;
                m_inv[l] <= '0;
            end
        end
        else
        begin
            m_valid <= i_valid && i_enable;
            if (i_valid && i_enable)
                m_data <= i_data;
            m_rd_lock_q <= i_read_lock;
            m_rd_err_q  <= i_read_err;
            // snapshots see the lane state from before this edge
            m_rf_lock <= (i_read_lock && !m_rd_lock_q) ? '0 : m_lock;
            m_rf_err  <= (i_read_err && !m_rd_err_q) ? '0 : m_err;
            for (int l = 0; l < LN; l++)
            begin
                t_good = (i_data[l].sh == rx_pcs_pkg::SH_DATA) ||
                         (i_data[l].sh == rx_pcs_pkg::SH_CTRL);
                t_lock = m_lock[l];
                t_run  = m_run[l];
                t_inv  = m_inv[l];
                if (!i_signal_ok)
                begin
                    t_lock = 1'b0;
                    t_run  = '0;
                    t_inv  = '0;
                end
                else if (i_valid && i_enable)
                begin
                    if (!t_lock)
                    begin
                        t_run = t_good ? t_run + 1'b1 : '0;
                        if (t_run == i_cfg.unlocked_limit)
                        begin
                            t_lock = 1'b1;
                            t_run  = '0;
                        end
                    end
                    else
                    begin
                        t_run = t_run + 1'b1;
                        if (!t_good)
                            t_inv = t_inv + 1'b1;
                        if (t_inv == i_cfg.sh_invalid_limit)
                        begin
                            t_lock = 1'b0;
                            t_run  = '0;
                            t_inv  = '0;
                        end
                        else if (t_run == i_cfg.locked_limit)
                        begin
                            t_run = '0;
                            t_inv = '0;
                        end
                    end
                end
                if (i_valid && i_enable && !t_good && (m_err[l] != '1))
                    m_err[l] <= m_err[l] + 1'b1;
                m_lock[l] <= t_lock;
                m_run[l]  <= t_run;
                m_inv[l]  <= t_inv;
            end
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    a_valid : assert property (@(posedge i_clock) disable iff (i_reset) o_valid == m_valid)
        else report_failure($sformatf("error o_valid expected %h got %h",
                                      $sampled(m_valid), $sampled(o_valid)));
    a_data : assert property (@(posedge i_clock) disable iff (i_reset)
        !m_valid || (o_data == m_data))
        else report_failure($sformatf("error o_data expected %h got %h",
                                      $sampled(m_data), $sampled(o_data)));
    a_lock : assert property (@(posedge i_clock) disable iff (i_reset)
        o_rf_block_lock == m_rf_lock)
        else report_failure($sformatf("error o_rf_block_lock expected %h got %h",
                                      $sampled(m_rf_lock), $sampled(o_rf_block_lock)));
    a_err : assert property (@(posedge i_clock) disable iff (i_reset)
        o_rf_err_count == m_rf_err)
        else report_failure($sformatf("error o_rf_err_count expected %h got %h",
                                      $sampled(m_rf_err), $sampled(o_rf_err_count)));

    // one block per lane where bad lanes get 00 or 11
    task automatic send_block(input rx_pcs_pkg::lock_vec_t bad, input logic valid);
        for (int l = 0; l < LN; l++)
        begin
            i_data[l].payload = {$random(seed), $random(seed)};
            if (bad[l])
                i_data[l].sh = ($random(seed) & 1) ? 2'b11 : 2'b00;
            else
                i_data[l].sh = ($random(seed) & 1) ? rx_pcs_pkg::SH_CTRL : rx_pcs_pkg::SH_DATA;
        end
        i_valid = valid;
        @(posedge i_clock);
        #1;
    endtask

    task automatic wait_rf_lock(input rx_pcs_pkg::lock_vec_t target, input int max_cycles);
        int n;
        n = 0;
        i_valid = 1'b0;
        while (o_rf_block_lock !== target)
        begin
            if (n == max_cycles)
                report_failure($sformatf("timed out waiting for lock pattern %h", target));
            else
            begin
                @(posedge i_clock);
                #1;
                n++;
            end
        end
    endtask

    initial
    begin
        seed        = 62;
        i_reset     = 1'b1;
        i_enable    = 1'b1;
        i_valid     = 1'b0;
        i_signal_ok = 1'b1;
        i_data      = '0;
        i_read_lock = 1'b0;
        i_read_err  = 1'b0;
        i_cfg       = '{unlocked_limit: 12'd8, locked_limit: 12'd16, sh_invalid_limit: 11'd4};
        repeat (5) @(posedge i_clock);
        #1;
        i_reset  = 1'b0;
        // nothing taken with enable or valid low
        i_enable = 1'b0;
        repeat (3) send_block('0, 1'b1);
        i_enable = 1'b1;
        repeat (2) send_block('0, 1'b0);
        // lane 1 restarts its run
        for (int i = 0; i < 12; i++)
            send_block({2'b00, (i == 3), 1'b0}, 1'b1);
        wait_rf_lock(4'hf, 8);
        // lane 0 keeps 3 bad per window while lane 2 drops and relocks
        for (int i = 0; i < 28; i++)
        begin
            send_block({1'b0, (i >= 8 && i < 16), 1'b0, (i % 6 == 0)}, 1'b1);
            if (i == 15)
                wait_rf_lock(4'b1011, 8);
        end
        wait_rf_lock(4'hf, 8);
        i_signal_ok = 1'b0;
        send_block('0, 1'b1);
        i_signal_ok = 1'b1;
        wait_rf_lock(4'h0, 8);
        for (int i = 0; i < 10; i++)
            send_block({(i < 2), 3'b000}, 1'b1);
        wait_rf_lock(4'hf, 8);
        // held reads act once
        i_read_lock = 1'b1;
        i_read_err  = 1'b1;
        repeat (3) send_block(4'b0010, 1'b1);
        i_read_lock = 1'b0;
        i_read_err  = 1'b0;
        send_block('0, 1'b0);
        i_read_err = 1'b1;
        send_block('0, 1'b0);
        i_read_err = 1'b0;
        repeat (200)
        begin
            i_enable    = ($random(seed) % 4) != 0;
            i_read_lock = ($random(seed) % 8) == 0;
            i_read_err  = ($random(seed) % 8) == 0;
            send_block(rx_pcs_pkg::lock_vec_t'($random(seed) & $random(seed)),
                       ($random(seed) % 4) != 0);
        end
        i_read_lock = 1'b0;
        i_read_err  = 1'b0;
        i_enable    = 1'b1;
        // every lane runs its error count into saturation and past it
        repeat (65536) send_block(4'hf, 1'b1);
        repeat (3) send_block('0, 1'b0);
        $display("test passed");
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/rx_pcs_pkg.sv
hdl/sh_window_counter.sv
hdl/block_lock_fsm.sv
hdl/lane_block_sync.sv
hdl/cor_status_reg.sv
hdl/rx_block_sync_top.sv
sim/rx_block_sync_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
    --top-module rx_block_sync_tb -o rx_sim \
    && ./obj_dir/rx_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
